//--- source/md_defs.svh
/*
 * Width and counter constants for the multiply/divide unit.
 * The operator set fixes the width at 32 bits, so MD_XLEN is not a tuning knob.
 */
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Operand, result and half-word widths
`define MD_XLEN 32
`define MD_HALF 16

// Intermediate word, two carry/sign bits above a full word
`define MD_IMD_W 34

// Division bit counter and its start value
`define MD_CNT_W 5
`define MD_DIV_LAST 31

`endif

//--- source/md_op_pkg.sv
/*
 * Operation-facing types of the multiply/divide unit.
 * Signed mode only affects MULH and DIV/REM; MULL ignores it.
 */
`default_nettype none

`include "md_defs.svh"

package md_op_pkg;

  typedef logic [`MD_XLEN-1:0] md_word_t;

  typedef enum logic [1:0] {
    MD_OP_MULL,
    MD_OP_MULH,
    MD_OP_DIV,
    MD_OP_REM
  } md_op_e;

  // a_signed sits in bit 0
  typedef struct packed {
    logic b_signed;
    logic a_signed;
  } md_sign_t;

  typedef struct packed {
    md_op_e   op;
    md_sign_t sign;
    md_word_t op_a;
    md_word_t op_b;
  } md_req_t;

endpackage

`default_nettype wire

//--- source/md_dp_pkg.sv
/*
 * Datapath types shared by the multiplier, the divider and the register block.
 * The intermediate word is read as MAC partial sums or as the divider remainder.
 */
`default_nettype none

`include "md_defs.svh"

package md_dp_pkg;
  import md_op_pkg::*;

  // Partial product view, upper sum with carry/sign bits over the kept low half
  typedef struct packed {
    logic [`MD_IMD_W-`MD_HALF-1:0] hi_ext;
    logic [`MD_HALF-1:0]           lo;
  } imd_mac_t;

  // Divider view, pad[0] carries the bit shifted out of the remainder
  typedef struct packed {
    logic [`MD_IMD_W-`MD_XLEN-1:0] pad;
    md_word_t                      rem;
  } imd_div_t;

  typedef union packed {
    imd_mac_t mac;
    imd_div_t div;
  } imd_word_u;

  typedef enum logic [1:0] {
    ALBL,
    ALBH,
    AHBL,
    AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    IDLE,
    ABS_A,
    ABS_B,
    COMP,
    LAST,
    CHANGE_SIGN,
    FINISH
  } div_state_e;

endpackage

`default_nettype wire

//--- source/md_mult_fast.sv
/*
 * 17x17 multiply-accumulate sequencer. MULL is valid in cycle 3, MULH in cycle 4.
 * Request and enable must stay stable until valid; state freezes while enable is low.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_defs.svh"

module md_mult_fast (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_en_i,
  input  md_op_pkg::md_req_t   req_i,
  input  md_dp_pkg::imd_word_u imd0_q_i,
  output md_dp_pkg::imd_word_u mac_d_o,
  output logic                 mult_valid_o
);
  import md_op_pkg::*;
  import md_dp_pkg::*;

  mult_state_e           state_q;
  mult_state_e           state_d;
  logic [`MD_HALF-1:0]   mult_op_a;
  logic [`MD_HALF-1:0]   mult_op_b;
  logic                  sign_a;
  logic                  sign_b;
  logic                  a_neg;
  logic                  b_neg;
  logic                  signed_mult;
  logic                  is_mull;
  logic [`MD_IMD_W-1:0]  accum;
  logic [`MD_IMD_W-1:0]  mac_res;

  assign a_neg       = req_i.sign.a_signed & req_i.op_a[`MD_XLEN-1];
  assign b_neg       = req_i.sign.b_signed & req_i.op_b[`MD_XLEN-1];
  assign signed_mult = req_i.sign.a_signed | req_i.sign.b_signed;
  assign is_mull     = (req_i.op == MD_OP_MULL);

  // Top bit of the 35-bit sum always equals bit 33, so 34 bits suffice
  assign mac_res = $signed({sign_a, mult_op_a}) * $signed({sign_b, mult_op_b}) +
                   $signed(accum);

  always_comb begin
    mult_op_a    = req_i.op_a[`MD_HALF-1:0];
    mult_op_b    = req_i.op_b[`MD_HALF-1:0];
    sign_a       = 1'b0;
    sign_b       = 1'b0;
    accum        = '0;
    mac_d_o      = mac_res;
    state_d      = state_q;
    mult_valid_o = 1'b0;

    case (state_q)
      ALBL: begin
        state_d = ALBH;
      end

      ALBH: begin
        mult_op_b = req_i.op_b[`MD_XLEN-1:`MD_HALF];
        sign_b    = b_neg;
        // al*bl has no sign and no carry beyond 32 bits
        accum     = `MD_IMD_W'(imd0_q_i.mac.hi_ext[`MD_HALF-1:0]);
        if (is_mull) begin
          mac_d_o.mac.hi_ext = {2'b00, mac_res[`MD_HALF-1:0]};
          mac_d_o.mac.lo     = imd0_q_i.mac.lo;
        end
        state_d = AHBL;
      end

      AHBL: begin
        mult_op_a = req_i.op_a[`MD_XLEN-1:`MD_HALF];
        sign_a    = a_neg;
        if (is_mull) begin
          accum              = `MD_IMD_W'(imd0_q_i.mac.hi_ext[`MD_HALF-1:0]);
          mac_d_o.mac.hi_ext = {2'b00, mac_res[`MD_HALF-1:0]};
          mac_d_o.mac.lo     = imd0_q_i.mac.lo;
          mult_valid_o       = mult_en_i;
          state_d            = ALBL;
        end else begin
          accum   = imd0_q_i;
          state_d = AHBH;
        end
      end

      AHBH: begin
        mult_op_a    = req_i.op_a[`MD_XLEN-1:`MD_HALF];
        mult_op_b    = req_i.op_b[`MD_XLEN-1:`MD_HALF];
        sign_a       = a_neg;
        sign_b       = b_neg;
        // Shift the running sum down one half-word, sign-extended for signed modes
        accum        = {{`MD_HALF{signed_mult & imd0_q_i.mac.hi_ext[`MD_IMD_W-`MD_HALF-1]}},
                        imd0_q_i.mac.hi_ext};
        mult_valid_o = mult_en_i;
        state_d      = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (mult_en_i) begin
      state_q <= state_d;
    end
  end

endmodule

`default_nettype wire

//--- source/md_div_long.sv
/*
 * Restoring long divider, one quotient bit per cycle, valid in cycle 37.
 * Divide by zero gives all ones (DIV) or operand A (REM), valid in cycle 2.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_defs.svh"

module md_div_long (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 div_en_i,
  input  md_op_pkg::md_req_t   req_i,
  input  md_dp_pkg::imd_word_u imd0_q_i,
  input  md_op_pkg::md_word_t  den_q_i,
  output md_dp_pkg::imd_word_u rem_d_o,
  output md_op_pkg::md_word_t  den_d_o,
  output logic                 div_valid_o
);
  import md_op_pkg::*;
  import md_dp_pkg::*;

  div_state_e            state_q;
  div_state_e            state_d;
  logic [`MD_CNT_W-1:0]  cnt_q;
  logic [`MD_CNT_W-1:0]  cnt_d;
  md_word_t              num_q;
  md_word_t              num_d;
  md_word_t              quot_q;
  md_word_t              quot_d;
  logic                  dbz_q;
  logic                  dbz_d;
  logic [`MD_XLEN:0]     add_a;
  md_word_t              add_b;
  logic [`MD_XLEN:0]     add_res;
  logic                  add_zero;
  logic                  is_ge;
  logic                  is_div;
  logic                  sign_a;
  logic                  sign_b;
  logic                  div_change_sign;
  logic                  rem_change_sign;
  md_word_t              next_rem;
  md_word_t              next_quot;

  // Shared subtractor, bit 32 is the borrow
  assign add_res  = add_a - {1'b0, add_b};
  assign add_zero = (add_res[`MD_XLEN-1:0] == '0);
  assign is_ge    = ~add_res[`MD_XLEN];

  assign next_rem  = is_ge ? add_res[`MD_XLEN-1:0] : imd0_q_i.div.rem;
  assign next_quot = quot_q | (md_word_t'(is_ge) << cnt_q);

  assign is_div          = (req_i.op == MD_OP_DIV);
  assign sign_a          = req_i.sign.a_signed & req_i.op_a[`MD_XLEN-1];
  assign sign_b          = req_i.sign.b_signed & req_i.op_b[`MD_XLEN-1];
  assign div_change_sign = (sign_a ^ sign_b) & ~dbz_q;
  assign rem_change_sign = sign_a;

  always_comb begin
    state_d     = state_q;
    cnt_d       = cnt_q - 1'b1;
    num_d       = num_q;
    quot_d      = quot_q;
    dbz_d       = dbz_q;
    rem_d_o     = imd0_q_i;
    den_d_o     = den_q_i;
    add_a       = '0;
    add_b       = req_i.op_b;
    div_valid_o = 1'b0;

    case (state_q)
      IDLE: begin
        // 0 - B is zero only for a zero divisor
        rem_d_o = is_div ? '1 : {2'b00, req_i.op_a};
        dbz_d   = add_zero;
        state_d = add_zero ? FINISH : ABS_A;
        cnt_d   = `MD_CNT_W'(`MD_DIV_LAST);
      end

      ABS_A: begin
        add_b   = req_i.op_a;
        quot_d  = '0;
        num_d   = sign_a ? add_res[`MD_XLEN-1:0] : req_i.op_a;
        state_d = ABS_B;
        cnt_d   = `MD_CNT_W'(`MD_DIV_LAST);
      end

      ABS_B: begin
        den_d_o = sign_b ? add_res[`MD_XLEN-1:0] : req_i.op_b;
        rem_d_o = `MD_IMD_W'(num_q[`MD_XLEN-1]);
        state_d = COMP;
        cnt_d   = `MD_CNT_W'(`MD_DIV_LAST);
      end

      COMP: begin
        add_a              = {imd0_q_i.div.pad[0], imd0_q_i.div.rem};
        add_b              = den_q_i;
        rem_d_o.div.pad    = {1'b0, next_rem[`MD_XLEN-1]};
        rem_d_o.div.rem    = {next_rem[`MD_XLEN-2:0], num_q[cnt_d]};
        quot_d             = next_quot;
        state_d            = (cnt_q == `MD_CNT_W'(1)) ? LAST : COMP;
      end

      LAST: begin
        add_a   = {imd0_q_i.div.pad[0], imd0_q_i.div.rem};
        add_b   = den_q_i;
        // From here on the word holds only the value to be returned
        rem_d_o = is_div ? {2'b00, next_quot} : {2'b00, next_rem};
        quot_d  = next_quot;
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        add_b = imd0_q_i.div.rem;
        if (is_div ? div_change_sign : rem_change_sign) begin
          rem_d_o = {2'b00, add_res[`MD_XLEN-1:0]};
        end
        state_d = FINISH;
      end

      FINISH: begin
        div_valid_o = div_en_i;
        state_d     = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      num_q   <= '0;
      quot_q  <= '0;
      dbz_q   <= 1'b0;
    end else if (div_en_i) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      num_q   <= num_d;
      quot_q  <= quot_d;
      dbz_q   <= dbz_d;
    end
  end

endmodule

`default_nettype wire

//--- source/md_imd_regs.sv
/*
 * Intermediate word and divisor registers shared by both sequencers.
 * Only one enable may be high at a time; the divider result wins the mux.
 */
`timescale 1ns/1ps
`default_nettype none

`include "md_defs.svh"

module md_imd_regs (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 mult_en_i,
  input  logic                 div_en_i,
  input  md_dp_pkg::imd_word_u mac_d_i,
  input  md_dp_pkg::imd_word_u rem_d_i,
  input  md_op_pkg::md_word_t  den_d_i,
  input  logic                 mult_valid_i,
  input  logic                 div_valid_i,
  output md_dp_pkg::imd_word_u imd0_q_o,
  output md_op_pkg::md_word_t  den_q_o,
  output md_op_pkg::md_word_t  result_o,
  output logic                 valid_o
);
  import md_op_pkg::*;
  import md_dp_pkg::*;

  md_word_t mac_lo;

  assign mac_lo = mac_d_i[`MD_XLEN-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imd0_q_o <= '0;
      den_q_o  <= '0;
    end else begin
      if (div_en_i) begin
        imd0_q_o <= rem_d_i;
        den_q_o  <= den_d_i;
      end else if (mult_en_i) begin
        imd0_q_o <= mac_d_i;
      end
    end
  end

  // Divider result sits in the register, multiplier result is still combinational
  assign result_o = div_en_i ? imd0_q_o.div.rem : mac_lo;
  assign valid_o  = mult_valid_i | div_valid_i;

endmodule

`default_nettype wire

//--- source/md_top.sv
/*
 * Standalone RV32M multiply/divide unit, no ready or back-pressure.
 * Raise one enable and hold it with req_i until valid_o, then drop it a cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module md_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                mult_en_i,
  input  logic                div_en_i,
  input  md_op_pkg::md_req_t  req_i,
  output md_op_pkg::md_word_t result_o,
  output logic                valid_o
);
  import md_op_pkg::*;
  import md_dp_pkg::*;

  imd_word_u imd0_q;
  imd_word_u mac_d;
  imd_word_u rem_d;
  md_word_t  den_d;
  md_word_t  den_q;
  logic      mult_valid;
  logic      div_valid;

  md_mult_fast u_mult (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mult_en_i    (mult_en_i),
    .req_i        (req_i),
    .imd0_q_i     (imd0_q),
    .mac_d_o      (mac_d),
    .mult_valid_o (mult_valid)
  );

  md_div_long u_div (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .div_en_i    (div_en_i),
    .req_i       (req_i),
    .imd0_q_i    (imd0_q),
    .den_q_i     (den_q),
    .rem_d_o     (rem_d),
    .den_d_o     (den_d),
    .div_valid_o (div_valid)
  );

  md_imd_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mult_en_i    (mult_en_i),
    .div_en_i     (div_en_i),
    .mac_d_i      (mac_d),
    .rem_d_i      (rem_d),
    .den_d_i      (den_d),
    .mult_valid_i (mult_valid),
    .div_valid_i  (div_valid),
    .imd0_q_o     (imd0_q),
    .den_q_o      (den_q),
    .result_o     (result_o),
    .valid_o      (valid_o)
  );

endmodule

`default_nettype wire

//--- test/md_top_chk.sv
/*
 * Port protocol assertions for md_top, attached by bind.
 * Assumes the requester drops its enable for a cycle after each valid.
 */
`timescale 1ns/1ps
`default_nettype none

module md_top_chk (
  input logic clk_i,
  input logic rst_ni,
  input logic mult_en_i,
  input logic div_en_i,
  input logic valid_i
);
  int valid_no_en_cnt = 0;
  int valid_long_cnt  = 0;
  int en_overlap_cnt  = 0;

  // Valid only comes out of an active sequencer
  valid_needs_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> (mult_en_i || div_en_i))
    else begin
      $error("valid_o high while both enables are low");
      valid_no_en_cnt++;
    end

  valid_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |=> !valid_i)
    else begin
      $error("valid_o stayed high for more than one cycle");
      valid_long_cnt++;
    end

  en_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(mult_en_i && div_en_i))
    else begin
      $error("mult_en_i and div_en_i high together");
      en_overlap_cnt++;
    end

endmodule

`default_nettype wire

//--- test/md_top_tb.sv
/*
 * Testbench for md_top with a directed table, then 40 random requests checked against
 * a reference model. Requests run back to back with one idle cycle in between.
 */
`timescale 1ns/1ps
`default_nettype none

module md_top_tb;
  import md_op_pkg::*;

  localparam int timeout_cycles = 100;
  localparam int num_random     = 40;

  // Signed-mode pairs written as {b_signed, a_signed}
  localparam md_sign_t sgn_uu = 2'b00;
  localparam md_sign_t sgn_su = 2'b01;
  localparam md_sign_t sgn_us = 2'b10;
  localparam md_sign_t sgn_ss = 2'b11;

  typedef struct packed {
    md_op_e   op;
    md_sign_t sign;
    md_word_t a;
    md_word_t b;
    md_word_t exp_val;
  } row_t;

  logic     clk;
  logic     rst_n;
  logic     mult_en;
  logic     div_en;
  md_req_t  req;
  md_word_t result;
  logic     valid;
  row_t     rows[$];
  int       error_cnt;
  int       test_cnt;
  logic     timed_out;

  md_top dut_i (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .mult_en_i (mult_en),
    .div_en_i  (div_en),
    .req_i     (req),
    .result_o  (result),
    .valid_o   (valid)
  );

  bind md_top md_top_chk u_chk (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mult_en_i (mult_en_i),
    .div_en_i  (div_en_i),
    .valid_i   (valid_o)
  );

  always #20 clk = ~clk;

  task automatic check_word(input string name, input md_word_t got, input md_word_t exp_val);
    if (got !== exp_val) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp_val);
      error_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp_val);
    if (got !== exp_val) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp_val);
      error_cnt++;
    end
  endtask

  // RISC-V M results from 64-bit products and truncating division
  function automatic md_word_t ref_result(input md_op_e op, input md_sign_t sign,
                                          input md_word_t a, input md_word_t b);
    logic signed [65:0] pa;
    logic signed [65:0] pb;
    logic signed [65:0] prod;
    logic               neg_a;
    logic               neg_b;
    md_word_t           mag_a;
    md_word_t           mag_b;
    md_word_t           quot;
    md_word_t           rem;
    neg_a = sign.a_signed & a[31];
    neg_b = sign.b_signed & b[31];
    pa    = {{34{neg_a}}, a};
    pb    = {{34{neg_b}}, b};
    prod  = pa * pb;
    mag_a = neg_a ? -a : a;
    mag_b = neg_b ? -b : b;
    quot  = '1;
    rem   = a;
    if (mag_b != '0) begin
      quot = mag_a / mag_b;
      rem  = mag_a % mag_b;
    end
    case (op)
      MD_OP_MULL: return prod[31:0];
      MD_OP_MULH: return prod[63:32];
      MD_OP_DIV:  return (b == '0) ? '1 : ((neg_a ^ neg_b) ? -quot : quot);
      default:    return (b == '0) ? a : (neg_a ? -rem : rem);
    endcase
  endfunction

  function automatic int expected_cycles(input md_op_e op, input md_word_t b);
    case (op)
      MD_OP_MULL: return 3;
      MD_OP_MULH: return 4;
      default:    return (b == '0) ? 2 : 37;
    endcase
  endfunction

  function automatic void add_row(input md_op_e op, input md_sign_t sign, input md_word_t a,
                                  input md_word_t b, input md_word_t exp_val);
    row_t r;
    r = '{op, sign, a, b, exp_val};
    rows.push_back(r);
  endfunction

  // Expected values worked out by hand
  task automatic load_table();
    add_row(MD_OP_MULL, sgn_uu, 32'h0000_0003, 32'h0000_0005, 32'h0000_000F);
    add_row(MD_OP_MULL, sgn_ss, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_row(MD_OP_MULL, sgn_uu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
    add_row(MD_OP_MULL, sgn_uu, 32'h0001_0003, 32'h0002_0005, 32'h000B_000F);
    add_row(MD_OP_MULL, sgn_su, 32'hFFFF_FFFF, 32'h0000_0002, 32'hFFFF_FFFE);
    add_row(MD_OP_MULL, sgn_us, 32'h0000_0003, 32'h8000_0000, 32'h8000_0000);
    add_row(MD_OP_MULH, sgn_uu, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    add_row(MD_OP_MULH, sgn_ss, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
    add_row(MD_OP_MULH, sgn_ss, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_row(MD_OP_MULH, sgn_uu, 32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF);
    add_row(MD_OP_MULH, sgn_su, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_row(MD_OP_MULH, sgn_us, 32'h8000_0000, 32'h8000_0000, 32'hC000_0000);
    add_row(MD_OP_MULH, sgn_ss, 32'h7FFF_FFFF, 32'h7FFF_FFFF, 32'h3FFF_FFFF);
    add_row(MD_OP_MULH, sgn_uu, 32'h0001_0003, 32'h0002_0005, 32'h0000_0002);
    add_row(MD_OP_DIV,  sgn_ss, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_row(MD_OP_REM,  sgn_ss, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
    add_row(MD_OP_DIV,  sgn_ss, 32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD);
    add_row(MD_OP_REM,  sgn_ss, 32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF);
    add_row(MD_OP_DIV,  sgn_uu, 32'hFFFF_FFF9, 32'h0000_0002, 32'h7FFF_FFFC);
    add_row(MD_OP_REM,  sgn_uu, 32'hFFFF_FFF9, 32'h0000_0002, 32'h0000_0001);
    add_row(MD_OP_DIV,  sgn_ss, 32'h0000_0064, 32'hFFFF_FFF9, 32'hFFFF_FFF2);
    add_row(MD_OP_REM,  sgn_ss, 32'h0000_0064, 32'hFFFF_FFF9, 32'h0000_0002);
    add_row(MD_OP_DIV,  sgn_uu, 32'h1234_5678, 32'h0000_0010, 32'h0123_4567);
    add_row(MD_OP_REM,  sgn_uu, 32'h1234_5678, 32'h0000_0010, 32'h0000_0008);
    // Divide by zero
    add_row(MD_OP_DIV,  sgn_ss, 32'h0000_1234, 32'h0000_0000, 32'hFFFF_FFFF);
    add_row(MD_OP_REM,  sgn_ss, 32'hDEAD_BEEF, 32'h0000_0000, 32'hDEAD_BEEF);
    add_row(MD_OP_DIV,  sgn_uu, 32'h0000_0000, 32'h0000_0000, 32'hFFFF_FFFF);
    add_row(MD_OP_REM,  sgn_uu, 32'h0000_0005, 32'h0000_0000, 32'h0000_0005);
  endtask

  // Runs one request by raising the enable, waiting for valid_o and dropping the enable
  task automatic run_op(input md_op_e op, input md_sign_t sign, input md_word_t a,
                        input md_word_t b, input md_word_t exp_val);
    int   cycles;
    int   exp_cycles;
    int   errs_before;
    logic seen;
    cycles      = 0;
    seen        = 1'b0;
    exp_cycles  = expected_cycles(op, b);
    errs_before = error_cnt;
    @(posedge clk);
    #2;
    req.op   = op;
    req.sign = sign;
    req.op_a = a;
    req.op_b = b;
    mult_en  = (op == MD_OP_MULL) || (op == MD_OP_MULH);
    div_en   = (op == MD_OP_DIV) || (op == MD_OP_REM);
    while (!seen && cycles < timeout_cycles) begin
      @(negedge clk);
      cycles++;
      check_bit("valid_o", valid, cycles == exp_cycles);
      seen = valid;
    end
    if (!seen) begin
      $display("Timeout: valid_o never rose within %0d cycles for %s", timeout_cycles,
               op.name());
      timed_out = 1'b1;
    end else begin
      check_word("result_o", result, exp_val);
      test_cnt++;
      $display("test %0d %s sign=%b a=0x%h b=0x%h result=0x%h cycle %0d: %s", test_cnt,
               op.name(), sign, a, b, result, cycles,
               (error_cnt == errs_before) ? "ok" : "mismatch");
    end
    @(posedge clk);
    #2;
    mult_en = 1'b0;
    div_en  = 1'b0;
  endtask

  initial begin
    int       assert_fails;
    md_op_e   op;
    md_sign_t sign;
    md_word_t a;
    md_word_t b;
    void'($urandom(19));
    clk       = 1'b0;
    rst_n     = 1'b0;
    mult_en   = 1'b0;
    div_en    = 1'b0;
    req       = '0;
    error_cnt = 0;
    test_cnt  = 0;
    timed_out = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Idle after reset
    repeat (5) begin
      @(negedge clk);
      check_bit("valid_o", valid, 1'b0);
    end
    test_cnt++;
    $display("test %0d reset idle: %s", test_cnt, (error_cnt == 0) ? "ok" : "mismatch");

    load_table();
    foreach (rows[i]) begin
      if (!timed_out) begin
        run_op(rows[i].op, rows[i].sign, rows[i].a, rows[i].b, rows[i].exp_val);
      end
    end

    repeat (num_random) begin
      case ($urandom_range(0, 3))
        0:       op = MD_OP_MULL;
        1:       op = MD_OP_MULH;
        2:       op = MD_OP_DIV;
        default: op = MD_OP_REM;
      endcase
      sign = md_sign_t'(2'($urandom_range(0, 3)));
      a    = $urandom;
      b    = $urandom;
      // Division uses DIV/DIVU style modes and the occasional zero or small divisor
      if (op == MD_OP_DIV || op == MD_OP_REM) begin
        sign.b_signed = sign.a_signed;
        if ($urandom_range(0, 9) == 0) begin
          b = '0;
        end else if ($urandom_range(0, 1) == 1) begin
          b = b >> 24;
        end
      end
      if (!timed_out) begin
        run_op(op, sign, a, b, ref_result(op, sign, a, b));
      end
    end

    assert_fails = dut_i.u_chk.valid_no_en_cnt + dut_i.u_chk.valid_long_cnt +
                   dut_i.u_chk.en_overlap_cnt;
    $display("tests: %0d, check errors: %0d, assertion failures: %0d", test_cnt, error_cnt,
             assert_fails);
    if (error_cnt == 0 && assert_fails == 0 && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/md_op_pkg.sv
source/md_dp_pkg.sv
source/md_mult_fast.sv
source/md_div_long.sv
source/md_imd_regs.sv
source/md_top.sv
test/md_top_chk.sv
test/md_top_tb.sv

//--- Makefile
VERILATOR := verilator
TOP       := md_top_tb
FILELIST  := project.f
VFLAGS    := --binary --timing --assert -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_LOG   := sim.log
RUN_ARGS  := +verilator+error+limit+1000
PASS_MSG  := Test completed successfully

SOURCES := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard source/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) | tee $(SIM_LOG)
	grep -q "$(PASS_MSG)" $(SIM_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
